//--- Makefile
VERILATOR  ?= verilator
TOP        := read_cache_tb
RTL_TOP    := read_cache_top
FILELIST   := read_cache_top.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- cache/cache_ctrl.sv
// read cache controller
// four-phase front end, lookup sequencing, refill on miss and response
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl
   import cache_addr_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  wire logic                         clk_i,
   input  wire logic                         reset_i,
   input  wire logic                         req_i,
   input  wire cache_addr_u                  addr_i,
   output logic                              ack_o,
   output logic [`CACHE_DATA_W-1:0]          rdata_o,
   output logic                              lookup_o,
   output cache_addr_u                       lookup_addr_o,
   input  wire logic                         hit_i,
   output logic                              refill_start_o,
   input  wire logic                         refill_done_i,
   output logic                              tag_wr_en_o,
   output logic [`CACHE_INDEX_W-1:0]         rd_index_o,
   output logic [`CACHE_WORD_OFF_W-1:0]      rd_word_o,
   input  wire logic [`CACHE_DATA_W-1:0]     rd_data_i
);

   ctrl_state_e state;
   cache_addr_u addr_q;
   logic        load_rdata;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= IDLE;
         ack_o <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (req_i) state <= LOOKUP; // ack is already low here
            end
            LOOKUP: begin
               if (hit_i) begin
                  state <= RESPOND;
                  ack_o <= 1'b1;
               end else begin
                  state <= REFILL;
               end
            end
            REFILL: begin
               // line is present once the channel is done
               if (refill_done_i) begin
                  state <= RESPOND;
                  ack_o <= 1'b1;
               end
            end
            RESPOND, WAIT_DROP: begin
               if (!req_i) begin
                  state <= IDLE;
                  ack_o <= 1'b0;
               end else begin
                  state <= WAIT_DROP;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign load_rdata = (state == LOOKUP && hit_i) || (state == REFILL && refill_done_i);

   always_ff @(posedge clk_i) begin
      if (state == IDLE && req_i) addr_q <= addr_i;
      if (load_rdata) rdata_o <= rd_data_i;
   end

   // lookup runs in the accept cycle so hit is ready in LOOKUP
   assign lookup_o       = (state == IDLE) && req_i;
   assign lookup_addr_o  = (state == IDLE) ? addr_i : addr_q;
   assign refill_start_o = (state == LOOKUP) && !hit_i;
   assign tag_wr_en_o    = (state == REFILL) && refill_done_i;

   assign rd_index_o = addr_q.f.index;
   assign rd_word_o  = addr_q.f.word;

   // ack only answers a pending request
   a_ack_needs_req: assert property (
      @(posedge clk_i) disable iff (reset_i)
      $rose(ack_o) |-> $past(req_i)
   );

endmodule

`default_nettype wire

//--- cache/cache_data_store.sv
// read cache data store
// one word written per refill beat, combinational read by index and word
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_data_store (
   input  wire logic                         clk_i,
   input  wire logic                         wr_en_i,
   input  wire logic [`CACHE_INDEX_W-1:0]    wr_index_i,
   input  wire logic [`CACHE_WORD_OFF_W-1:0] wr_word_i,
   input  wire logic [`CACHE_DATA_W-1:0]     wr_data_i,
   input  wire logic [`CACHE_INDEX_W-1:0]    rd_index_i,
   input  wire logic [`CACHE_WORD_OFF_W-1:0] rd_word_i,
   output logic [`CACHE_DATA_W-1:0]          rd_data_o
);

   // lines x words
   logic [`CACHE_DATA_W-1:0] line_mem [`CACHE_LINES][`CACHE_LINE_WORDS];

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         line_mem[wr_index_i][wr_word_i] <= wr_data_i;
      end
   end

   // the controller registers this into its response
   assign rd_data_o = line_mem[rd_index_i][rd_word_i];

endmodule

`default_nettype wire

//--- cache/cache_refill_channel.sv
// read cache refill channel
// fetches all words of a line over the valid/ack back end, in word order
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_refill_channel
   import cache_addr_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  wire logic                         clk_i,
   input  wire logic                         reset_i,
   input  wire logic                         refill_start_i,
   input  wire cache_addr_u                  line_addr_i,
   output logic                              busy_o,
   output logic                              done_o,
   output logic                              wr_en_o,
   output logic [`CACHE_INDEX_W-1:0]         wr_index_o,
   output logic [`CACHE_WORD_OFF_W-1:0]      wr_word_o,
   output logic [`CACHE_DATA_W-1:0]          wr_data_o,
   output logic [`CACHE_ADDR_W-1:0]          be_addr_o,
   output logic                              be_valid_o,
   input  wire logic                         be_ack_i,
   input  wire logic [`CACHE_DATA_W-1:0]     be_rdata_i
);

   refill_state_e                 state;
   logic [`CACHE_WORD_OFF_W-1:0]  word_cnt;
   cache_addr_u                   line_q;
   cache_addr_u                   be_addr_u;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state    <= RF_IDLE;
         word_cnt <= '0;
      end else begin
         case (state)
            RF_IDLE: begin
               if (refill_start_i) begin
                  state    <= RF_FETCH;
                  word_cnt <= '0;
               end
            end
            RF_FETCH: begin
               if (be_ack_i) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (&word_cnt) state <= RF_END; // last word of the line
               end
            end
            RF_END:  state <= RF_IDLE; // latency cycle before done
            default: state <= RF_IDLE;
         endcase
      end
   end

   // tag and index of the line being fetched
   always_ff @(posedge clk_i) begin
      if (state == RF_IDLE && refill_start_i) line_q <= line_addr_i;
   end

   // word-aligned back-end address
   always_comb begin
      be_addr_u            = line_q;
      be_addr_u.f.word     = word_cnt;
      be_addr_u.f.byte_off = '0;
   end

   assign be_addr_o  = be_addr_u.raw;
   assign be_valid_o = (state == RF_FETCH); // stays up across words
   assign busy_o     = (state != RF_IDLE);
   assign done_o     = (state == RF_END);

   // each acked word goes straight into the data store
   assign wr_en_o    = (state == RF_FETCH) && be_ack_i;
   assign wr_index_o = line_q.f.index;
   assign wr_word_o  = word_cnt;
   assign wr_data_o  = be_rdata_i;

   // no back-end request unless a refill was started
   a_valid_only_after_start: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (state == RF_IDLE && !refill_start_i) |=> !be_valid_o
   );

   a_no_start_while_busy: assert property (
      @(posedge clk_i) disable iff (reset_i)
      refill_start_i |-> !busy_o
   );

endmodule

`default_nettype wire

//--- cache/cache_tag_store.sv
// read cache tag store
// tag and valid bit per line, registered hit compare on lookup
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tag_store
   import cache_addr_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire logic                      lookup_i,
   input  wire cache_addr_u               addr_i,
   input  wire logic                      wr_en_i,
   input  wire logic [`CACHE_INDEX_W-1:0] wr_index_i,
   input  wire logic [`CACHE_TAG_W-1:0]   wr_tag_i,
   output logic                           hit_o
);

   logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
   logic [`CACHE_LINES-1:0] valid_q;

   // valid bits and the hit flag start cleared
   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         valid_q <= '0;
         hit_o   <= 1'b0;
      end else begin
         if (wr_en_i) begin
            valid_q[wr_index_i] <= 1'b1;
         end
         if (lookup_i) begin
            hit_o <= valid_q[addr_i.f.index] && (tag_mem[addr_i.f.index] == addr_i.f.tag);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         tag_mem[wr_index_i] <= wr_tag_i; // line becomes resident
      end
   end

   // the controller only looks up in idle and only writes tags in refill
   a_no_lookup_during_write: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(lookup_i && wr_en_i)
   );

endmodule

`default_nettype wire

//--- common/cache_addr_pkg.sv
// read cache address layout
// one byte address seen either as a raw word or as tag/index/offset fields
`default_nettype none

package cache_addr_pkg;

`include "cache_macros.svh"

   // msb first: tag, index, word in line, byte in word
   typedef struct packed {
      logic [`CACHE_TAG_W-1:0]      tag;
      logic [`CACHE_INDEX_W-1:0]    index;
      logic [`CACHE_WORD_OFF_W-1:0] word;
      logic [`CACHE_BYTE_OFF_W-1:0] byte_off;
   } cache_addr_fields_t;

   // both views cover the same 12 bits
   typedef union packed {
      logic [`CACHE_ADDR_W-1:0] raw;
      cache_addr_fields_t       f;
   } cache_addr_u;

endpackage

`default_nettype wire

//--- common/cache_ctrl_pkg.sv
// read cache state encodings
// controller and refill channel FSM states
`default_nettype none

package cache_ctrl_pkg;

   // front-end controller
   typedef enum logic [2:0] {
      IDLE      = 3'd0, // waiting for req
      LOOKUP    = 3'd1, // hit result available
      REFILL    = 3'd2, // line being fetched
      RESPOND   = 3'd3, // first cycle with ack high
      WAIT_DROP = 3'd4  // ack held until req falls
   } ctrl_state_e;

   // back-end refill channel
   typedef enum logic [1:0] {
      RF_IDLE  = 2'd0,
      RF_FETCH = 2'd1, // one word per ack
      RF_END   = 2'd2  // latency cycle after the last word
   } refill_state_e;

endpackage

`default_nettype wire

//--- common/cache_macros.svh
// read cache sizes
// field widths of the byte address and the line geometry
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// front-end byte address
`define CACHE_ADDR_W 12

// front-end and back-end word
`define CACHE_DATA_W 32

`define CACHE_BYTE_OFF_W 2 // bytes in a word
`define CACHE_WORD_OFF_W 2 // four words per line
`define CACHE_INDEX_W 4    // sixteen lines

// tag takes whatever is left of the address
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WORD_OFF_W - `CACHE_BYTE_OFF_W)

`define CACHE_LINES 16

// words held in one line
`define CACHE_LINE_WORDS (1 << `CACHE_WORD_OFF_W)

`endif

//--- logic/read_cache_top.sv
// read cache top
// controller, tag store, data store and refill channel wired together
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module read_cache_top
   import cache_addr_pkg::*;
(
   input  wire logic                     clk_i,
   input  wire logic                     reset_i,
   // front end, four-phase
   input  wire logic                     req_i,
   input  wire logic [`CACHE_ADDR_W-1:0] addr_i,
   output logic                          ack_o,
   output logic [`CACHE_DATA_W-1:0]      rdata_o,
   // back end, valid/ack
   output logic [`CACHE_ADDR_W-1:0]      be_addr_o,
   output logic                          be_valid_o,
   input  wire logic                     be_ack_i,
   input  wire logic [`CACHE_DATA_W-1:0] be_rdata_i
);

   logic                          lookup;
   cache_addr_u                   lookup_addr;
   logic                          hit;
   logic                          refill_start;
   logic                          refill_done;
   logic                          tag_wr_en;
   logic [`CACHE_INDEX_W-1:0]     rd_index;
   logic [`CACHE_WORD_OFF_W-1:0]  rd_word;
   logic [`CACHE_DATA_W-1:0]      rd_data;
   logic                          wr_en;
   logic [`CACHE_INDEX_W-1:0]     wr_index;
   logic [`CACHE_WORD_OFF_W-1:0]  wr_word;
   logic [`CACHE_DATA_W-1:0]      wr_data;

   cache_ctrl u_cache_ctrl (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .req_i          (req_i),
      .addr_i         (addr_i),
      .ack_o          (ack_o),
      .rdata_o        (rdata_o),
      .lookup_o       (lookup),
      .lookup_addr_o  (lookup_addr),
      .hit_i          (hit),
      .refill_start_o (refill_start),
      .refill_done_i  (refill_done),
      .tag_wr_en_o    (tag_wr_en),
      .rd_index_o     (rd_index),
      .rd_word_o      (rd_word),
      .rd_data_i      (rd_data)
   );

   // new tag comes from the latched request address
   cache_tag_store u_cache_tag_store (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .lookup_i   (lookup),
      .addr_i     (lookup_addr),
      .wr_en_i    (tag_wr_en),
      .wr_index_i (lookup_addr.f.index),
      .wr_tag_i   (lookup_addr.f.tag),
      .hit_o      (hit)
   );

   cache_data_store u_cache_data_store (
      .clk_i      (clk_i),
      .wr_en_i    (wr_en),
      .wr_index_i (wr_index),
      .wr_word_i  (wr_word),
      .wr_data_i  (wr_data),
      .rd_index_i (rd_index),
      .rd_word_i  (rd_word),
      .rd_data_o  (rd_data)
   );

   cache_refill_channel u_cache_refill_channel (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .refill_start_i (refill_start),
      .line_addr_i    (lookup_addr),
      .busy_o         (),            // only checked inside the channel
      .done_o         (refill_done),
      .wr_en_o        (wr_en),
      .wr_index_o     (wr_index),
      .wr_word_o      (wr_word),
      .wr_data_o      (wr_data),
      .be_addr_o      (be_addr_o),
      .be_valid_o     (be_valid_o),
      .be_ack_i       (be_ack_i),
      .be_rdata_i     (be_rdata_i)
   );

endmodule

`default_nettype wire

//--- read_cache_top.f
+incdir+common
common/cache_addr_pkg.sv
common/cache_ctrl_pkg.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_refill_channel.sv
cache/cache_ctrl.sv
logic/read_cache_top.sv
verif/tb_clock_gen.sv
verif/read_cache_tb.sv

//--- verif/read_cache_tb.sv
// read cache testbench
// back-end memory model with random ack delay, four-phase reads, checking assertions
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module read_cache_tb
   import cache_ctrl_pkg::*;
;
   localparam int IDX_LSB   = `CACHE_BYTE_OFF_W + `CACHE_WORD_OFF_W;
   localparam int TAG_LSB   = IDX_LSB + `CACHE_INDEX_W;
   localparam int ACK_LIMIT = 200; // cycles, covers a refill with slow acks
   localparam int DROP_LIMIT = 8;

   logic                     clk, reset;
   logic                     req, ack, be_valid, be_ack;
   logic [`CACHE_ADDR_W-1:0] addr, be_addr;
   logic [`CACHE_DATA_W-1:0] rdata, be_rdata;

   logic [`CACHE_TAG_W-1:0]  model_tag [`CACHE_LINES];
   logic [`CACHE_LINES-1:0]  model_valid;
   logic                     expect_hit;
   logic [3:0]               beats;   // back-end acks in the current request
   logic [31:0]              delay_rng;
   logic [31:0]              addr_rng;
   logic                     timed_out;
   int                       errors;
   int                       timeouts;

   tb_clock_gen u_tb_clock_gen (.clk_o(clk), .reset_o(reset));

   read_cache_top u_read_cache_top (
      .clk_i(clk), .reset_i(reset),
      .req_i(req), .addr_i(addr), .ack_o(ack), .rdata_o(rdata),
      .be_addr_o(be_addr), .be_valid_o(be_valid), .be_ack_i(be_ack), .be_rdata_i(be_rdata)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // backing memory contents: address, its inverse, then a marker byte
   function automatic logic [`CACHE_DATA_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] a);
      logic [`CACHE_ADDR_W-1:0] w;
      w = {a[`CACHE_ADDR_W-1:`CACHE_BYTE_OFF_W], {`CACHE_BYTE_OFF_W{1'b0}}};
      return {w, ~w, 8'h5c};
   endfunction

   // back-end memory, acks each word after 0 to 3 idle cycles
   initial begin
      int  delay_left;
      logic armed;
      be_ack    = 1'b0;
      be_rdata  = '0;
      delay_rng = 32'h730c_18f4;
      armed     = 1'b0;
      delay_left = 0;
      forever begin
         @(posedge clk);
         #1;
         be_ack = 1'b0;
         if (be_valid && !armed) begin
            delay_rng  = xorshift32(delay_rng);
            delay_left = int'(delay_rng[1:0]);
            armed      = 1'b1;
         end
         if (be_valid && armed) begin
            if (delay_left == 0) begin
               be_ack   = 1'b1;
               be_rdata = mem_word(be_addr);
               armed    = 1'b0;
            end else begin
               delay_left--;
            end
         end
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) beats <= '0;
      else if (!req) beats <= '0; // cleared between requests
      else if (be_valid && be_ack) beats <= beats + 1'b1;
   end

   a_rdata: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> rdata == mem_word(addr))
      else begin
         errors++;
         $display("Error: rdata_o = %h, expected %h", $sampled(rdata), mem_word($sampled(addr)));
      end

   a_be_addr: assert property (@(posedge clk) disable iff (reset)
      be_valid && be_ack |-> be_addr == {addr[`CACHE_ADDR_W-1:IDX_LSB], beats[1:0], 2'b00})
      else begin
         errors++;
         $display("Error: be_addr_o = %h, expected %h", $sampled(be_addr),
                  {$sampled(addr[`CACHE_ADDR_W-1:IDX_LSB]), $sampled(beats[1:0]), 2'b00});
      end

   a_beat_count: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> beats == (expect_hit ? 4'd0 : 4'd4))
      else begin
         errors++;
         $display("Error: beats = %h, expected %h", $sampled(beats),
                  $sampled(expect_hit) ? 4'd0 : 4'd4);
      end

   a_no_be_on_hit: assert property (@(posedge clk) disable iff (reset) be_valid |-> !expect_hit)
      else begin
         errors++;
         $display("back-end read started for a line that should be resident");
      end

   // hit: req sampled high two edges before ack is seen high
   a_hit_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) && expect_hit |-> $past(req, 2) && !$past(req, 3))
      else begin
         errors++;
         $display("hit response did not arrive exactly 2 cycles after the request");
      end

   a_ack_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ack)
      else begin
         errors++;
         $display("ack was high when reset was released");
      end

   // ack is set on the edge that still sees req high
   a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else begin
         errors++;
         $display("ack rose without a request");
      end

   a_ack_held: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
      else begin
         errors++;
         $display("ack dropped while the request was still high");
      end

   a_ack_release: assert property (@(posedge clk) disable iff (reset) ack && !req |=> !ack)
      else begin
         errors++;
         $display("ack stayed high after the request dropped");
      end

   task automatic read_word(input logic [`CACHE_ADDR_W-1:0] a);
      logic [`CACHE_INDEX_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0]   tg;
      ctrl_state_e               st;
      int                        n;
      int                        hold;
      if (timed_out) return;
      idx        = a[IDX_LSB +: `CACHE_INDEX_W];
      tg         = a[TAG_LSB +: `CACHE_TAG_W];
      hold       = int'(a[3:2]); // cycles req stays up after ack
      expect_hit = model_valid[idx] && (model_tag[idx] == tg);
      addr       = a;
      req        = 1'b1;
      for (n = 0; n < ACK_LIMIT && !ack; n++) begin
         @(posedge clk);
         #1;
      end
      if (!ack) begin
         st = u_read_cache_top.u_cache_ctrl.state;
         $display("timeout: no ack for address %h, controller in %s", a, st.name());
         timeouts++;
         timed_out = 1'b1;
         req       = 1'b0;
         return;
      end
      // master is slow to release, ack has to stay up meanwhile
      repeat (hold) begin
         @(posedge clk);
         #1;
      end
      req              = 1'b0;
      model_valid[idx] = 1'b1; // line resident from now on
      model_tag[idx]   = tg;
      for (n = 0; n < DROP_LIMIT && ack; n++) begin
         @(posedge clk);
         #1;
      end
      if (ack) begin
         $display("timeout: ack still high after the request dropped");
         timeouts++;
         timed_out = 1'b1;
      end
   endtask

   initial begin
      int n;
      req         = 1'b0;
      addr        = '0;
      expect_hit  = 1'b0;
      model_valid = '0;
      timed_out   = 1'b0;
      errors      = 0;
      timeouts    = 0;
      addr_rng    = xorshift32(32'h730c_18f4);
      for (n = 0; n < 40 && reset; n++) begin
         @(posedge clk);
         #1;
      end
      if (reset) begin
         $display("timeout: reset never released");
         timeouts++;
         timed_out = 1'b1;
      end
      read_word(12'h000); // cold miss
      read_word(12'h004); // same line hits
      read_word(12'h00c);
      read_word(12'h008);
      read_word(12'h100); // index 0, new tag
      read_word(12'h000); // old tag was evicted
      read_word(12'h3f4);
      read_word(12'h3f0);
      for (n = 0; n < 48; n++) begin
         addr_rng = xorshift32(addr_rng);
         read_word(addr_rng[`CACHE_ADDR_W-1:0]);
      end
      repeat (4) @(posedge clk);
      $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// testbench clock and reset
// 4 ns clock, reset held high for the first 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   initial begin
      reset_o = 1'b1;
      repeat (8) @(posedge clk_o);
      #1 reset_o = 1'b0; // released off the edge like other inputs
   end

endmodule

`default_nettype wire
